// File: source/tile_pkg.sv
package tile_pkg;

    // Element and result widths
    localparam int DATA_W = 8;
    localparam int ACC_W  = 32;

    // Two signed products plus one carry bit
    localparam int PSUM_W = 2 * DATA_W + 1;

    typedef logic signed [DATA_W-1:0] weight_t;

    // Activation vector, x0 in the low byte
    typedef struct packed {
        logic signed [DATA_W-1:0] x1;
        logic signed [DATA_W-1:0] x0;
    } act_vec_t;

    typedef logic signed [PSUM_W-1:0] psum_t;
    typedef logic signed [ACC_W-1:0]  acc_t;

    typedef enum logic [2:0] {
        IDLE        = 3'd0,
        LOAD_WEIGHT = 3'd1,
        COMPUTE     = 3'd2,
        DRAIN       = 3'd3,
        DONE        = 3'd4
    } tile_state_t;

endpackage

// File: source/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 2
) (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       push,
    input  payload_t                   push_data,
    input  logic                       pop,
    output payload_t                   pop_data,
    output logic [$clog2(DEPTH+1)-1:0] count,
    output logic                       full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t         mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic             empty;
    logic             do_push;
    logic             do_pop;

    // Pointer wrap, also for depths that are not a power of two
    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == CNT_W'(DEPTH));

    // Push into a full queue is lost
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    // Show-ahead head entry, zero when nothing is stored
    assign pop_data = empty ? payload_t'(0) : mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// File: source/systolic_array.sv
`timescale 1ns/10ps

// Cell (r,c) holds weight w_rc, row r carries element x_r,
// column c carries the partial sum downwards
module systolic_array import tile_pkg::*; (
    input  logic     clk,
    input  logic     reset,
    input  logic     weight_shift,
    input  weight_t  weight_col0,
    input  weight_t  weight_col1,
    input  logic     feed_valid,
    input  act_vec_t act,
    output psum_t    psum_col0,
    output psum_t    psum_col1
);

    // Stationary weights
    weight_t w00;
    weight_t w01;
    weight_t w10;
    weight_t w11;

    // Row inputs and right-going activation registers
    logic signed [DATA_W-1:0] x0_in;
    logic signed [DATA_W-1:0] x1_skew;
    logic signed [DATA_W-1:0] a00;
    logic signed [DATA_W-1:0] a10;

    // Row 0 partial sums going down
    psum_t p00;
    psum_t p01;

    // Full-width products, one per cell
    logic signed [2*DATA_W-1:0] prod00;
    logic signed [2*DATA_W-1:0] prod01;
    logic signed [2*DATA_W-1:0] prod10;
    logic signed [2*DATA_W-1:0] prod11;

    // Weights enter at row 0 and move one row down per shift
    always_ff @(posedge clk) begin
        if (weight_shift) begin
            w00 <= weight_col0;
            w01 <= weight_col1;
            w10 <= w00;
            w11 <= w01;
        end
    end

    // Zero activations when nothing is fed
    assign x0_in = feed_valid ? act.x0 : '0;

    assign prod00 = x0_in * w00;
    assign prod01 = a00 * w01;
    assign prod10 = x1_skew * w10;
    assign prod11 = a10 * w11;

    always_ff @(posedge clk) begin
        if (reset) begin
            x1_skew   <= '0;
            a00       <= '0;
            a10       <= '0;
            p00       <= '0;
            p01       <= '0;
            psum_col0 <= '0;
            psum_col1 <= '0;
        end else begin
            // Row 1 lags row 0 by one cycle
            x1_skew <= feed_valid ? act.x1 : '0;

            // Pass activations to column 1
            a00 <= x0_in;
            a10 <= x1_skew;

            // Top row starts each column sum
            p00 <= prod00;
            p01 <= prod01;

            // Bottom row completes it
            psum_col0 <= p00 + prod10;
            psum_col1 <= p01 + prod11;
        end
    end

endmodule

// File: source/column_accumulator.sv
`timescale 1ns/10ps

module column_accumulator import tile_pkg::*; (
    input  logic  clk,
    input  logic  reset,
    input  logic  acc_clear,
    input  logic  sum_valid,
    input  psum_t psum_col0,
    input  psum_t psum_col1,
    output acc_t  result0,
    output acc_t  result1
);

    localparam int EXT_W = ACC_W - PSUM_W;

    acc_t psum_ext0;
    acc_t psum_ext1;

    // Column 1 sum arrives one cycle after column 0
    logic sum_valid_d;

    // Sign extension to result width
    assign psum_ext0 = {{EXT_W{psum_col0[PSUM_W-1]}}, psum_col0};
    assign psum_ext1 = {{EXT_W{psum_col1[PSUM_W-1]}}, psum_col1};

    always_ff @(posedge clk) begin
        if (reset) begin
            sum_valid_d <= 1'b0;
        end else begin
            sum_valid_d <= sum_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            result0 <= '0;
            result1 <= '0;
        end else if (acc_clear) begin
            result0 <= '0;
            result1 <= '0;
        end else begin
            if (sum_valid) begin
                result0 <= result0 + psum_ext0;
            end
            // Totals hold between runs
            if (sum_valid_d) begin
                result1 <= result1 + psum_ext1;
            end
        end
    end

endmodule

// File: source/tile_controller.sv
`timescale 1ns/10ps

module tile_controller import tile_pkg::*; #(
    parameter int ACT_DEPTH = 16
) (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           start,
    input  logic [$clog2(ACT_DEPTH+1)-1:0] act_count,
    output logic                           weight_pop,
    output logic                           weight_shift,
    output logic                           act_pop,
    output logic                           feed_valid,
    output logic                           acc_clear,
    output logic                           sum_valid,
    output logic                           busy,
    output logic                           result_valid
);

    localparam int CNT_W = $clog2(ACT_DEPTH + 1);

    // Fixed phase lengths
    localparam logic [CNT_W-1:0] LOAD_LAST  = CNT_W'(1);
    localparam logic [CNT_W-1:0] DRAIN_LAST = CNT_W'(2);

    tile_state_t      state;
    logic [CNT_W-1:0] cycle_cnt;
    logic [CNT_W-1:0] vec_count;

    // Feed delay line, column 0 sums come out two cycles later
    logic feed_d1;
    logic feed_d2;

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= IDLE;
            cycle_cnt <= '0;
            vec_count <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    cycle_cnt <= '0;
                    if (start) begin
                        // Vectors buffered at this point form the run
                        vec_count <= act_count;
                        state     <= LOAD_WEIGHT;
                    end
                end

                LOAD_WEIGHT: begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                    if (cycle_cnt == LOAD_LAST) begin
                        cycle_cnt <= '0;
                        // Empty buffer skips straight to drain
                        state     <= (vec_count == '0) ? DRAIN : COMPUTE;
                    end
                end

                COMPUTE: begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                    if (cycle_cnt == vec_count - 1'b1) begin
                        cycle_cnt <= '0;
                        state     <= DRAIN;
                    end
                end

                DRAIN: begin
                    cycle_cnt <= cycle_cnt + 1'b1;
                    if (cycle_cnt == DRAIN_LAST) begin
                        cycle_cnt <= '0;
                        state     <= DONE;
                    end
                end

                DONE: begin
                    state <= IDLE;
                end

                default: begin
                    cycle_cnt <= '0;
                    state     <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            feed_d1 <= 1'b0;
            feed_d2 <= 1'b0;
        end else begin
            feed_d1 <= feed_valid;
            feed_d2 <= feed_d1;
        end
    end

    // One pop and one shift per load cycle
    assign weight_pop   = (state == LOAD_WEIGHT);
    assign weight_shift = (state == LOAD_WEIGHT);

    // One vector per compute cycle
    assign act_pop    = (state == COMPUTE);
    assign feed_valid = (state == COMPUTE);

    // Clear lands on the edge that accepts start
    assign acc_clear = (state == IDLE) && start;
    assign sum_valid = feed_d2;

    assign busy         = (state != IDLE);
    assign result_valid = (state == DONE);

endmodule

// File: source/mlp_tile.sv
`timescale 1ns/10ps

module mlp_tile import tile_pkg::*; #(
    parameter int ACT_DEPTH = 16
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     weight_push_col0,
    input  logic     weight_push_col1,
    input  weight_t  weight_data,
    input  logic     act_valid,
    input  act_vec_t act_data,
    input  logic     start,
    output logic     busy,
    output logic     result_valid,
    output acc_t     result0,
    output acc_t     result1
);

    localparam int CNT_W = $clog2(ACT_DEPTH + 1);

    // Controller strobes
    logic weight_pop;
    logic weight_shift;
    logic act_pop;
    logic feed_valid;
    logic acc_clear;
    logic sum_valid;

    weight_t          weight_col0;
    weight_t          weight_col1;
    act_vec_t         act_head;
    logic [CNT_W-1:0] act_count;
    logic             act_push;
    psum_t            psum_col0;
    psum_t            psum_col1;

    // Vectors are only taken while idle
    assign act_push = act_valid && !busy;

    // Column weight queues, row-1 weight pushed first
    sync_fifo #(
        .payload_t (weight_t),
        .DEPTH     (2)
    ) weight_fifo_col0 (
        .clk       (clk),
        .reset     (reset),
        .push      (weight_push_col0),
        .push_data (weight_data),
        .pop       (weight_pop),
        .pop_data  (weight_col0),
        .count     (),
        .full      ()
    );

    sync_fifo #(
        .payload_t (weight_t),
        .DEPTH     (2)
    ) weight_fifo_col1 (
        .clk       (clk),
        .reset     (reset),
        .push      (weight_push_col1),
        .push_data (weight_data),
        .pop       (weight_pop),
        .pop_data  (weight_col1),
        .count     (),
        .full      ()
    );

    sync_fifo #(
        .payload_t (act_vec_t),
        .DEPTH     (ACT_DEPTH)
    ) act_buffer (
        .clk       (clk),
        .reset     (reset),
        .push      (act_push),
        .push_data (act_data),
        .pop       (act_pop),
        .pop_data  (act_head),
        .count     (act_count),
        .full      ()
    );

    systolic_array array_i (
        .clk          (clk),
        .reset        (reset),
        .weight_shift (weight_shift),
        .weight_col0  (weight_col0),
        .weight_col1  (weight_col1),
        .feed_valid   (feed_valid),
        .act          (act_head),
        .psum_col0    (psum_col0),
        .psum_col1    (psum_col1)
    );

    column_accumulator accum_i (
        .clk       (clk),
        .reset     (reset),
        .acc_clear (acc_clear),
        .sum_valid (sum_valid),
        .psum_col0 (psum_col0),
        .psum_col1 (psum_col1),
        .result0   (result0),
        .result1   (result1)
    );

    tile_controller #(
        .ACT_DEPTH (ACT_DEPTH)
    ) ctrl_i (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .act_count    (act_count),
        .weight_pop   (weight_pop),
        .weight_shift (weight_shift),
        .act_pop      (act_pop),
        .feed_valid   (feed_valid),
        .acc_clear    (acc_clear),
        .sum_valid    (sum_valid),
        .busy         (busy),
        .result_valid (result_valid)
    );

endmodule

// File: testbench/tb_clock_gen.sv
`timescale 1ns/10ps

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 5,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic reset
);

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Release just after an edge, like the other inputs
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
    end

endmodule

// File: testbench/mlp_tile_checker.sv
`timescale 1ns/10ps

module mlp_tile_checker (
    input logic clk,
    input logic reset,
    input logic start,
    input logic busy,
    input logic result_valid,
    input logic acc_clear
);

    int assert_fails = 0;

    // Result strobe is a single-cycle pulse
    result_pulse_a: assert property (@(posedge clk) disable iff (reset)
        result_valid |=> !result_valid)
        else begin
            $error("result_valid held for more than one cycle");
            assert_fails++;
        end

    // No result on the accepting cycle nor before the shortest run can end
    no_result_at_start_a: assert property (@(posedge clk) disable iff (reset)
        (start && !busy) |-> !result_valid [*6])
        else begin
            $error("result_valid high too soon after start was accepted");
            assert_fails++;
        end

    idle_after_reset_a: assert property (@(posedge clk)
        reset |=> !busy)
        else begin
            $error("busy high right after reset");
            assert_fails++;
        end

    // Clear comes with the start of a run
    clear_then_busy_a: assert property (@(posedge clk) disable iff (reset)
        acc_clear |=> busy)
        else begin
            $error("busy not raised after acc_clear");
            assert_fails++;
        end

endmodule

// File: testbench/mlp_tile_tb.sv
`timescale 1ns/10ps

module mlp_tile_tb import tile_pkg::*; ();

    localparam int ACT_DEPTH       = 16;
    localparam int CLK_PERIOD      = 10;
    localparam int WATCHDOG_CYCLES = 20 * (ACT_DEPTH + 20);

    logic     clk;
    logic     reset;
    logic     weight_push_col0;
    logic     weight_push_col1;
    weight_t  weight_data;
    logic     act_valid;
    act_vec_t act_data;
    logic     start;
    logic     busy;
    logic     result_valid;
    acc_t     result0;
    acc_t     result1;

    // Model of the queues inside the tile
    weight_t  wq0 [$];
    weight_t  wq1 [$];
    act_vec_t act_model [$];

    int   seed = 32'hec003d4b;
    int   error_count = 0;
    int   runs_done = 0;
    int   cycle_no = 0;
    int   start_cycle;
    int   exp_n;
    int   exp_sum0;
    int   exp_sum1;
    logic run_pending = 1'b0;

    tb_clock_gen #(.HALF_PERIOD(CLK_PERIOD / 2), .RESET_CYCLES(2)) clk_gen_i (
        .clk   (clk),
        .reset (reset)
    );

    mlp_tile #(.ACT_DEPTH(ACT_DEPTH)) dut_i (
        .clk              (clk),
        .reset            (reset),
        .weight_push_col0 (weight_push_col0),
        .weight_push_col1 (weight_push_col1),
        .weight_data      (weight_data),
        .act_valid        (act_valid),
        .act_data         (act_data),
        .start            (start),
        .busy             (busy),
        .result_valid     (result_valid),
        .result0          (result0),
        .result1          (result1)
    );

    bind mlp_tile mlp_tile_checker checker_i (
        .clk          (clk),
        .reset        (reset),
        .start        (start),
        .busy         (busy),
        .result_valid (result_valid),
        .acc_clear    (acc_clear)
    );

    always @(posedge clk) cycle_no <= cycle_no + 1;

    // Expected column sums, packed as {sum1, sum0}
    function automatic logic [63:0] expected_sums(input weight_t w00, input weight_t w01,
                                                  input weight_t w10, input weight_t w11,
                                                  input act_vec_t vecs[$]);
        int sum0;
        int sum1;
        sum0 = 0;
        sum1 = 0;
        foreach (vecs[i]) begin
            sum0 += int'($signed(vecs[i].x0)) * int'(w00) + int'($signed(vecs[i].x1)) * int'(w10);
            sum1 += int'($signed(vecs[i].x0)) * int'(w01) + int'($signed(vecs[i].x1)) * int'(w11);
        end
        return {sum1, sum0};
    endfunction

    function automatic act_vec_t random_vector();
        logic [31:0] r;
        r = $random(seed);
        return act_vec_t'(r[15:0]);
    endfunction

    task automatic check_value(input string what, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Error at %0d ns: %s is %0d, expected %0d", $time, what,
                     $signed(actual), $signed(expected));
            error_count++;
        end
    endtask

    // Full column queues drop the push
    task automatic push_weight(input int col, input weight_t value);
        @(posedge clk);
        #1;
        weight_data = value;
        if (col == 0) begin
            weight_push_col0 = 1'b1;
            if (wq0.size() < 2) wq0.push_back(value);
        end else begin
            weight_push_col1 = 1'b1;
            if (wq1.size() < 2) wq1.push_back(value);
        end
        @(posedge clk);
        #1;
        weight_push_col0 = 1'b0;
        weight_push_col1 = 1'b0;
    endtask

    // Row-1 weight first in each column
    task automatic push_random_weights();
        push_weight(0, weight_t'($random(seed)));
        push_weight(0, weight_t'($random(seed)));
        push_weight(1, weight_t'($random(seed)));
        push_weight(1, weight_t'($random(seed)));
    endtask

    task automatic push_vector(input act_vec_t v);
        @(posedge clk);
        #1;
        act_valid = 1'b1;
        act_data  = v;
        if (!run_pending && act_model.size() < ACT_DEPTH) act_model.push_back(v);
        @(posedge clk);
        #1;
        act_valid = 1'b0;
    endtask

    // Only called while the tile is idle
    task automatic start_tile();
        weight_t     w00;
        weight_t     w01;
        weight_t     w10;
        weight_t     w11;
        logic [63:0] sums;
        @(posedge clk);
        #1;
        start = 1'b1;
        w10 = (wq0.size() > 0) ? wq0.pop_front() : '0;
        w00 = (wq0.size() > 0) ? wq0.pop_front() : '0;
        w11 = (wq1.size() > 0) ? wq1.pop_front() : '0;
        w01 = (wq1.size() > 0) ? wq1.pop_front() : '0;
        sums = expected_sums(w00, w01, w10, w11, act_model);
        exp_sum0 = sums[31:0];
        exp_sum1 = sums[63:32];
        exp_n = act_model.size();
        act_model.delete();
        start_cycle = cycle_no;
        run_pending = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    // Start strobe that the tile is expected to ignore
    task automatic pulse_start();
        @(posedge clk);
        #1;
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_result();
        wait (!run_pending);
        @(posedge clk);
    endtask

    // Compare at mid-cycle, where outputs are settled
    always @(negedge clk) begin
        if (!reset && result_valid) begin
            if (!run_pending) begin
                $display("result_valid pulsed at %0d ns with no run started", $time);
                error_count++;
            end else begin
                if (cycle_no - start_cycle != exp_n + 6) begin
                    $display("Result arrived %0d cycles after start instead of %0d",
                             cycle_no - start_cycle, exp_n + 6);
                    error_count++;
                end
                check_value("result0", result0, exp_sum0);
                check_value("result1", result1, exp_sum1);
                runs_done++;
                run_pending = 1'b0;
            end
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Simulation timed out waiting for a result");
        $display("=== FAIL ===");
        $finish;
    end

    initial begin
        weight_push_col0 = 1'b0;
        weight_push_col1 = 1'b0;
        weight_data      = '0;
        act_valid        = 1'b0;
        act_data         = '0;
        start            = 1'b0;
        wait (reset === 1'b0);
        @(posedge clk);
        check_value("busy after reset", busy, 0);
        check_value("result0 after reset", result0, 0);
        check_value("result1 after reset", result1, 0);

        // Single vector, fixed weights
        push_weight(0, 8'sd5);
        push_weight(0, 8'sd3);
        push_weight(1, 8'sd7);
        push_weight(1, -8'sd2);
        push_vector('{x1: -8'sd6, x0: 8'sd4});
        start_tile();
        wait_result();

        // Full buffer of random vectors
        push_random_weights();
        repeat (ACT_DEPTH) push_vector(random_vector());
        start_tile();
        wait_result();

        // Empty buffer
        push_random_weights();
        start_tile();
        wait_result();

        // Overfilled buffer, then pushes during the run
        push_random_weights();
        repeat (ACT_DEPTH + 2) push_vector(random_vector());
        start_tile();
        repeat (3) push_vector(random_vector());
        wait_result();

        // Start while busy, then back-to-back runs
        push_random_weights();
        repeat (4) push_vector(random_vector());
        start_tile();
        pulse_start();
        wait_result();
        repeat (2) begin
            push_random_weights();
            repeat (5) push_vector(random_vector());
            start_tile();
            wait_result();
        end

        repeat (2) @(posedge clk);
        error_count += dut_i.checker_i.assert_fails;
        $display("Runs completed: %0d, errors: %0d", runs_done, error_count);
        if (error_count == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: mlp_tile.f
source/tile_pkg.sv
source/sync_fifo.sv
source/systolic_array.sv
source/column_accumulator.sv
source/tile_controller.sv
source/mlp_tile.sv
testbench/tb_clock_gen.sv
testbench/mlp_tile_checker.sv
testbench/mlp_tile_tb.sv
